//--- ecc_defines.svh
`ifndef ECC_DEFINES_SVH
`define ECC_DEFINES_SVH

// ======================================================================
// SEC-DED geometry for the 91-bit checker.
// ======================================================================

// Number of data bits in one word.
`define ECC_DATA_WIDTH 91

// Number of check bits in one word.
`define ECC_PARITY_WIDTH 8

// Hamming position held in the low column bits.
`define ECC_POS_WIDTH 7

// Cycles from input sample to registered result.
`define ECC_PIPE_DEPTH 2

`endif

//--- ecc_pkg.sv
`include "ecc_defines.svh"

package ecc_pkg;

    typedef logic [`ECC_DATA_WIDTH-1:0]   ecc_data_t;
    typedef logic [`ECC_PARITY_WIDTH-1:0] ecc_parity_t;

    // Received check bits XOR computed check bits.
    typedef logic [`ECC_PARITY_WIDTH-1:0] ecc_syndrome_t;

    typedef struct packed {
        ecc_data_t   data;
        ecc_parity_t parity;
    } ecc_codeword_t;

    typedef struct packed {
        logic sbit_err;
        logic dbit_err;
    } ecc_flags_t;

    typedef struct packed {
        ecc_data_t   data;
        ecc_parity_t parity_out;
        ecc_flags_t  flags;
    } ecc_result_t;

    // Column code of one data bit.
    // Low bits are the idx-th non power of two from 3 upward.
    // Top bit makes the column weight odd.
    function automatic ecc_parity_t ecc_column(input int unsigned idx);
        logic [`ECC_POS_WIDTH-1:0] pos;
        int unsigned               seen;
        ecc_parity_t               col;
        pos  = '0;
        seen = 0;
        col  = '0;
        for (int unsigned v = 3; v < (1 << `ECC_POS_WIDTH); v++) begin
            if ((v & (v - 1)) != 0) begin
                if (seen == idx) begin
                    pos = v[`ECC_POS_WIDTH-1:0];
                end
                seen++;
            end
        end
        col[`ECC_POS_WIDTH-1:0]    = pos;
        col[`ECC_PARITY_WIDTH-1]   = ~^pos;
        return col;
    endfunction

endpackage

//--- ecc_parity_gen.sv
`timescale 1ns/100ps

`include "ecc_defines.svh"

module ecc_parity_gen
    import ecc_pkg::*;
(
    input  ecc_data_t   data,
    output ecc_parity_t parity
);

    // ==================================================================
    // Row selection from the shared column rule
    // ==================================================================

    // Data bits that feed check bit row.
    function automatic ecc_data_t row_mask(input int unsigned row);
        ecc_data_t   sel;
        ecc_parity_t col;
        sel = '0;
        for (int unsigned i = 0; i < `ECC_DATA_WIDTH; i++) begin
            col    = ecc_column(i);
            sel[i] = col[row];
        end
        return sel;
    endfunction

    // ==================================================================
    // Check bit reduction
    // ==================================================================

    genvar j;
    generate
        for (j = 0; j < `ECC_PARITY_WIDTH; j++) begin : g_row
            localparam ecc_data_t ROW_SEL = row_mask(j);

            // One XOR tree per check bit.
            assign parity[j] = ^(data & ROW_SEL);
        end
    endgenerate

endmodule

//--- ecc_syndrome_decode.sv
`timescale 1ns/100ps

`include "ecc_defines.svh"

module ecc_syndrome_decode
    import ecc_pkg::*;
(
    input  ecc_syndrome_t syndrome,
    output ecc_data_t     mask,
    output ecc_flags_t    flags
);

    logic syn_zero;
    logic syn_onehot;
    logic data_hit;

    // ==================================================================
    // Data bit match
    // ==================================================================

    // Each data bit owns one odd weight column of three or more ones,
    // so at most one mask bit can be set.
    genvar i;
    generate
        for (i = 0; i < `ECC_DATA_WIDTH; i++) begin : g_match
            localparam ecc_parity_t COL = ecc_column(i);

            assign mask[i] = (syndrome == COL);
        end
    endgenerate

    assign data_hit = |mask;

    // ==================================================================
    // Syndrome class
    // ==================================================================

    assign syn_zero = (syndrome == '0);

    // Single check bit in error.
    assign syn_onehot = !syn_zero && ((syndrome & (syndrome - 1'b1)) == '0);

    always_comb begin
        flags = '0;
        if (syn_zero) begin
            flags = '0;
        end else if (data_hit) begin
            flags.sbit_err = 1'b1;
        end else if (syn_onehot) begin
            flags.sbit_err = 1'b1;
        end else begin
            // Not correctable.
            flags.dbit_err = 1'b1;
        end
    end

endmodule

//--- ecc_91_cal.sv
`timescale 1ns/100ps

`include "ecc_defines.svh"

module ecc_91_cal
    import ecc_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  logic          in_valid,
    input  ecc_codeword_t in_word,
    input  logic          bypass,
    output logic          out_valid,
    output ecc_result_t   out_word
);

    // Valid bit per stage, oldest at the top.
    logic [`ECC_PIPE_DEPTH-1:0] valid_sr;

    ecc_parity_t   parity_calc;
    ecc_syndrome_t syndrome;

    // Stage 1 payload.
    ecc_syndrome_t s1_syndrome;
    ecc_data_t     s1_data;
    ecc_parity_t   s1_parity;
    logic          s1_bypass;

    // Decoder outputs for the stage 1 word.
    ecc_data_t  dec_mask;
    ecc_flags_t dec_flags;

    ecc_result_t result;

    // ==================================================================
    // Input side: encode and syndrome
    // ==================================================================

    ecc_parity_gen u_parity_gen (
        .data   (in_word.data),
        .parity (parity_calc)
    );

    assign syndrome = in_word.parity ^ parity_calc;

    // ==================================================================
    // Valid pipeline
    // ==================================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_sr <= '0;
        end else begin
            valid_sr <= {valid_sr[`ECC_PIPE_DEPTH-2:0], in_valid};
        end
    end

    assign out_valid = valid_sr[`ECC_PIPE_DEPTH-1];

    // ==================================================================
    // Stage 1 registers
    // ==================================================================

    always_ff @(posedge clk) begin
        if (in_valid) begin
            s1_syndrome <= syndrome;
            s1_data     <= in_word.data;
            s1_parity   <= parity_calc;
            s1_bypass   <= bypass;
        end
    end

    // ==================================================================
    // Decode and correction
    // ==================================================================

    ecc_syndrome_decode u_syndrome_decode (
        .syndrome (s1_syndrome),
        .mask     (dec_mask),
        .flags    (dec_flags)
    );

    always_comb begin
        result.parity_out = s1_parity;
        if (s1_bypass) begin
            // Raw data, no error report.
            result.data  = s1_data;
            result.flags = '0;
        end else begin
            result.data  = s1_data ^ dec_mask;
            result.flags = dec_flags;
        end
    end

    // ==================================================================
    // Stage 2 registers
    // ==================================================================

    always_ff @(posedge clk) begin
        if (valid_sr[0]) begin
            out_word <= result;
        end
    end

endmodule

//--- ecc_91_cal_asserts.sv
`timescale 1ns/100ps

`include "ecc_defines.svh"

module ecc_91_cal_asserts
    import ecc_pkg::*;
(
    input logic        clk,
    input logic        reset,
    input logic        in_valid,
    input logic        bypass,
    input logic        out_valid,
    input ecc_result_t out_word
);

    // Failed assertions, read back by the testbench.
    int unsigned fail_count = 0;

    // ==================================================================
    // Pipeline properties
    // ==================================================================

    a_reset_clears: assert property (@(posedge clk) reset |=> !out_valid)
        else begin
            $error("out_valid high in the cycle after reset");
            fail_count++;
        end

    a_flags_exclusive: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> !(out_word.flags.sbit_err && out_word.flags.dbit_err))
        else begin
            $error("sbit_err and dbit_err both high");
            fail_count++;
        end

    a_bypass_no_flags: assert property (@(posedge clk) disable iff (reset)
        (out_valid && $past(bypass, 2)) |-> (out_word.flags == '0))
        else begin
            $error("flags set on a bypassed word");
            fail_count++;
        end

    a_valid_latency: assert property (@(posedge clk) disable iff (reset)
        out_valid == $past(in_valid, 2))
        else begin
            $error("out_valid does not follow in_valid by two cycles");
            fail_count++;
        end

endmodule

//--- ecc_91_cal_tb.sv
`timescale 1ns/100ps

`include "ecc_defines.svh"

module ecc_91_cal_tb
    import ecc_pkg::*;
();

    localparam int unsigned NUM_WORDS      = 2000;
    localparam int unsigned TIMEOUT_CYCLES = 3 * NUM_WORDS + 100;
    localparam int unsigned CW_BITS        = `ECC_DATA_WIDTH + `ECC_PARITY_WIDTH;

    logic          clk = 1'b0;
    logic          reset;
    logic          in_valid;
    ecc_codeword_t in_word;
    logic          bypass;
    logic          out_valid;
    ecc_result_t   out_word;

    ecc_parity_t col_tab [`ECC_DATA_WIDTH];
    ecc_result_t exp_q [$];
    ecc_result_t got_exp;
    int unsigned errors = 0;
    int unsigned checked = 0;
    int unsigned cycle_count = 0;

    ecc_91_cal u_dut (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_word   (in_word),
        .bypass    (bypass),
        .out_valid (out_valid),
        .out_word  (out_word)
    );

    bind ecc_91_cal ecc_91_cal_asserts u_asserts (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .bypass    (bypass),
        .out_valid (out_valid),
        .out_word  (out_word)
    );

    always #50 clk = ~clk;

    // ==================================================================
    // Reference model
    // ==================================================================

    // Hamming positions skip powers of two.
    // Top bit makes the column weight odd.
    function automatic void build_columns();
        int unsigned v;
        int unsigned n;
        v = 3;
        n = 0;
        while (n < `ECC_DATA_WIDTH) begin
            if ($countones(v) != 1) begin
                col_tab[n] = {($countones(v) % 2) == 0, v[`ECC_POS_WIDTH-1:0]};
                n++;
            end
            v++;
        end
    endfunction

    function automatic ecc_parity_t model_parity(ecc_data_t d);
        ecc_parity_t p;
        p = '0;
        for (int i = 0; i < `ECC_DATA_WIDTH; i++) begin
            if (d[i]) begin
                p = p ^ col_tab[i];
            end
        end
        return p;
    endfunction

    task automatic make_word(output ecc_codeword_t cw, output logic byp,
                             output ecc_result_t exp);
        logic [95:0] raw;
        ecc_data_t   orig;
        int unsigned kind;
        int unsigned pat;
        int unsigned p1;
        int unsigned p2;
        raw       = {$urandom(), $urandom(), $urandom()};
        orig      = raw[`ECC_DATA_WIDTH-1:0];
        cw.data   = orig;
        cw.parity = model_parity(orig);
        kind      = $urandom_range(4);
        byp       = (kind == 4);
        pat       = byp ? $urandom_range(3) : kind;
        exp.flags = '0;
        case (pat)
            1: begin
                p1 = $urandom_range(`ECC_DATA_WIDTH - 1);
                cw.data[p1] = ~cw.data[p1];
                exp.flags.sbit_err = 1'b1;
            end
            2: begin
                p1 = $urandom_range(`ECC_PARITY_WIDTH - 1);
                cw.parity[p1] = ~cw.parity[p1];
                exp.flags.sbit_err = 1'b1;
            end
            3: begin
                p1 = $urandom_range(CW_BITS - 1);
                do begin
                    p2 = $urandom_range(CW_BITS - 1);
                end while (p2 == p1);
                cw[p1] = ~cw[p1];
                cw[p2] = ~cw[p2];
                exp.flags.dbit_err = 1'b1;
            end
            default: begin
            end
        endcase
        // Double errors are left as received.
        exp.data = (pat == 3) ? cw.data : orig;
        if (byp) begin
            exp.data  = cw.data;
            exp.flags = '0;
        end
        exp.parity_out = model_parity(cw.data);
    endtask

    // ==================================================================
    // Compare tasks
    // ==================================================================

    task automatic check_data(string name, ecc_data_t exp, ecc_data_t act);
        if (act !== exp) begin
            $display("error at %0t: %s expected %h got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_parity(string name, ecc_parity_t exp, ecc_parity_t act);
        if (act !== exp) begin
            $display("error at %0t: %s expected %h got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_flags(string name, ecc_flags_t exp, ecc_flags_t act);
        if (act !== exp) begin
            $display("error at %0t: %s expected %b got %b", $time, name, exp, act);
            errors++;
        end
    endtask

    // Outputs settle well before the falling edge.
    always @(negedge clk) begin
        if (!reset && out_valid) begin
            if (exp_q.size() == 0) begin
                $display("Result at %0t arrived with no word in flight.", $time);
                errors++;
            end else begin
                got_exp = exp_q.pop_front();
                check_data("out_word.data", got_exp.data, out_word.data);
                check_parity("out_word.parity_out", got_exp.parity_out,
                             out_word.parity_out);
                check_flags("out_word.flags", got_exp.flags, out_word.flags);
                checked++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles with %0d results outstanding.",
                     cycle_count, exp_q.size());
            $display("Finished with errors");
            $finish;
        end
    end

    // ==================================================================
    // Stimulus
    // ==================================================================

    initial begin
        ecc_codeword_t cw;
        logic          byp;
        ecc_result_t   exp;
        int unsigned   sent;
        int unsigned   total;
        void'($urandom(32'h484a_c2ed));
        build_columns();
        reset    = 1'b1;
        in_valid = 1'b1;
        in_word  = '0;
        bypass   = 1'b0;
        sent     = 0;
        // Words offered during reset must never come out.
        repeat (5) @(posedge clk);
        in_valid <= 1'b0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        while (sent < NUM_WORDS) begin
            @(posedge clk);
            if ($urandom_range(3) == 0) begin
                in_valid <= 1'b0;
            end else begin
                make_word(cw, byp, exp);
                in_word  <= cw;
                bypass   <= byp;
                in_valid <= 1'b1;
                exp_q.push_back(exp);
                sent++;
            end
        end
        @(posedge clk);
        in_valid <= 1'b0;
        bypass   <= 1'b0;
        // Drain, then watch a few more cycles for stray results.
        repeat (10) @(posedge clk);
        if (exp_q.size() != 0) begin
            $display("%0d words never produced a result.", exp_q.size());
            errors++;
        end
        total = errors + u_dut.u_asserts.fail_count;
        $display("Sent %0d words, checked %0d results, %0d check errors, %0d assertion failures",
                 sent, checked, errors, u_dut.u_asserts.fail_count);
        if (total == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- build.f
+incdir+.
ecc_pkg.sv
ecc_parity_gen.sv
ecc_syndrome_decode.sv
ecc_91_cal.sv
ecc_91_cal_asserts.sv
ecc_91_cal_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the ECC checker testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
TOP=ecc_91_cal_tb

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

rm -rf "$OBJ" "$LOG"

verilator --binary --timing --assert -Wno-fatal \
    -f build.f --top-module "$TOP" -Mdir "$OBJ"
status=$?
if [ $status -ne 0 ]; then
    echo "Compile failed with status $status"
    exit 1
fi

"./$OBJ/V$TOP" +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Finished with errors" "$LOG"; then
    echo "Simulation FAILED"
    exit 1
fi

echo "Simulation PASSED"
exit 0
